//--- logic/cart_cmd_top.sv
`timescale 1ns/1ns

module cart_cmd_top
  import spi_cmd_pkg::*;
  import mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              spi_sck,
  input  logic              spi_ss_n,
  input  logic              spi_mosi,
  input  logic              ext_clk,
  input  logic [7:0]        mem_data_in,
  input  logic              mem_rq_rdy,
  output logic              spi_miso,
  output logic [addr_w-1:0] mem_addr,
  output logic [7:0]        mem_data_out,
  output logic              mem_rrq,
  output logic              mem_wrq,
  output mapper_t           mapper,
  output logic [addr_w-1:0] rom_mask,
  output logic [addr_w-1:0] sram_mask,
  output logic [7:0]        feature_bits
);

  logic                  cmd_strobe;
  logic                  param_strobe;
  logic [7:0]            rx_byte;
  logic [7:0]            cmd_byte;
  logic [7:0]            tx_byte;
  logic [byte_cnt_w-1:0] byte_cnt;
  logic                  rd_start;
  logic                  wr_start;
  logic                  next_addr;
  logic [freq_w-1:0]     freq_count;

  spi_byte_rx i_spi_byte_rx (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_sck      (spi_sck),
    .spi_ss_n     (spi_ss_n),
    .spi_mosi     (spi_mosi),
    .tx_byte      (tx_byte),
    .spi_miso     (spi_miso),
    .cmd_strobe   (cmd_strobe),
    .param_strobe (param_strobe),
    .rx_byte      (rx_byte),
    .cmd_byte     (cmd_byte),
    .byte_cnt     (byte_cnt)
  );

  mcu_cmd i_mcu_cmd (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_strobe   (cmd_strobe),
    .param_strobe (param_strobe),
    .rx_byte      (rx_byte),
    .cmd_byte     (cmd_byte),
    .byte_cnt     (byte_cnt),
    .next_addr    (next_addr),
    .mem_data_in  (mem_data_in),
    .freq_count   (freq_count),
    .tx_byte      (tx_byte),
    .rd_start     (rd_start),
    .wr_start     (wr_start),
    .mem_addr     (mem_addr),
    .mem_data_out (mem_data_out),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .sram_mask    (sram_mask),
    .feature_bits (feature_bits)
  );

  mem_rq_fsm i_mem_rq_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_start   (rd_start),
    .wr_start   (wr_start),
    .mem_rq_rdy (mem_rq_rdy),
    .mem_rrq    (mem_rrq),
    .mem_wrq    (mem_wrq),
    .next_addr  (next_addr)
  );

  sysclk_meter i_sysclk_meter (
    .clk        (clk),
    .rst_n      (rst_n),
    .ext_clk    (ext_clk),
    .freq_count (freq_count)
  );

endmodule

//--- logic/mcu_cmd.sv
`timescale 1ns/1ns

module mcu_cmd
  import spi_cmd_pkg::*;
  import mem_map_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_strobe,
  input  logic                  param_strobe,
  input  logic [7:0]            rx_byte,
  input  logic [7:0]            cmd_byte,
  input  logic [byte_cnt_w-1:0] byte_cnt,
  input  logic                  next_addr,
  input  logic [7:0]            mem_data_in,
  input  logic [freq_w-1:0]     freq_count,
  output logic [7:0]            tx_byte,
  output logic                  rd_start,
  output logic                  wr_start,
  output logic [addr_w-1:0]     mem_addr,
  output logic [7:0]            mem_data_out,
  output mapper_t               mapper,
  output logic [addr_w-1:0]     rom_mask,
  output logic [addr_w-1:0]     sram_mask,
  output logic [7:0]            feature_bits
);

  cmd_op_t           op;
  logic              any_strobe;
  logic              mem_op;
  logic              auto_inc;
  logic [freq_w-1:0] freq_latch;

  // 24-bit value sent high byte first in parameters 2..4
  function automatic logic [addr_w-1:0] load_be(input logic [addr_w-1:0] cur,
                                                input logic [byte_cnt_w-1:0] cnt,
                                                input logic [7:0] data);
    logic [addr_w-1:0] nxt;
    nxt = cur;
    case (cnt)
      byte_cnt_w'(2): nxt[23:16] = data;
      byte_cnt_w'(3): nxt[15:8]  = data;
      byte_cnt_w'(4): nxt[7:0]   = data;
      default: ;
    endcase
    return nxt;
  endfunction

  assign op         = cmd_op_t'(cmd_byte[7:4]);
  assign any_strobe = cmd_strobe | param_strobe;
  assign mem_op     = (op == op_mem_read) || (op == op_mem_write);
  assign auto_inc   = cmd_byte[auto_inc_bit] && (byte_cnt >= byte_cnt_w'(2));

  ////////////////////////////////////////////////////////////////////////////
  // configuration and address
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mapper       <= map_hi;
      rom_mask     <= '0;
      sram_mask    <= '0;
      feature_bits <= '0;
      mem_addr     <= '0;
      rd_start     <= 1'b0;
      wr_start     <= 1'b0;
    end else begin
      rd_start <= any_strobe && (op == op_mem_read);
      wr_start <= param_strobe && (op == op_mem_write);
      if (cmd_strobe) begin
        if (op == op_set_mapper)
          mapper <= mapper_t'(cmd_byte[2:0]);
      end else if (param_strobe) begin
        case (op)
          op_set_addr: begin
            if (byte_cnt == byte_cnt_w'(2))
              mem_addr <= {rx_byte, 16'h0000};
            else
              mem_addr <= load_be(mem_addr, byte_cnt, rx_byte);
          end
          op_rom_mask:  rom_mask  <= load_be(rom_mask, byte_cnt, rx_byte);
          op_sram_mask: sram_mask <= load_be(sram_mask, byte_cnt, rx_byte);
          op_misc: begin
            if (cmd_byte == misc_feature_cmd)
              feature_bits <= rx_byte;
          end
          default: ;
        endcase
      end else if (next_addr && mem_op && auto_inc) begin
        mem_addr <= mem_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (param_strobe && (op == op_mem_write))
      mem_data_out <= rx_byte;
    if (cmd_strobe && (cmd_byte == info_freq_cmd))
      freq_latch <= freq_count;
  end

  ////////////////////////////////////////////////////////////////////////////
  // readback byte, shifted out during the following SPI byte
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_byte <= '0;
    end else if (next_addr && (op == op_mem_read)) begin
      tx_byte <= mem_data_in;
    end else if (any_strobe && (op == op_info)) begin
      case (cmd_byte)
        info_signature_cmd: tx_byte <= signature_byte;
        info_echo_cmd:      tx_byte <= rx_byte;
        info_freq_cmd: begin
          // count goes out MSB first
          case (byte_cnt)
            byte_cnt_w'(2): tx_byte <= freq_latch[freq_w-1 -: 8];
            byte_cnt_w'(3): tx_byte <= freq_latch[freq_w-9 -: 8];
            byte_cnt_w'(4): tx_byte <= freq_latch[freq_w-17 -: 8];
            byte_cnt_w'(5): tx_byte <= freq_latch[freq_w-25 -: 8];
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

//--- logic/mem_map_pkg.sv
package mem_map_pkg;

  // memory address and both masks
  localparam int addr_w = 24;

  typedef enum logic [2:0] {
    map_lo   = 3'd0,
    map_hi   = 3'd1,
    map_exhi = 3'd2,
    map_sa1  = 3'd3,
    map_bsx  = 3'd4,
    map_menu = 3'd5
  } mapper_t;

  // clk cycles per frequency window
  localparam int meter_window = 1000;
  localparam int freq_w       = 32;

  typedef enum logic [1:0] {
    rq_idle    = 2'd0,
    rq_request = 2'd1,
    rq_wait    = 2'd2
  } mem_rq_state_t;

endpackage

//--- logic/mem_rq_fsm.sv
`timescale 1ns/1ns

module mem_rq_fsm
  import mem_map_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic rd_start,
  input  logic wr_start,
  input  logic mem_rq_rdy,
  output logic mem_rrq,
  output logic mem_wrq,
  output logic next_addr
);

  mem_rq_state_t state;
  logic [1:0]    rdy_buf;
  logic          rdy_rise;

  assign rdy_rise = rdy_buf[0] & ~rdy_buf[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= rq_idle;
      mem_rrq   <= 1'b0;
      mem_wrq   <= 1'b0;
      rdy_buf   <= '0;
      next_addr <= 1'b0;
    end else begin
      rdy_buf   <= {rdy_buf[0], mem_rq_rdy};
      next_addr <= 1'b0;
      mem_rrq   <= 1'b0;
      mem_wrq   <= 1'b0;
      case (state)
        rq_idle: begin
          if (rd_start || wr_start) begin
            // one-cycle request pulse
            mem_rrq <= rd_start;
            mem_wrq <= wr_start;
            state   <= rq_request;
          end
        end
        rq_request: state <= rq_wait;
        rq_wait: begin
          // advance the address once memory answers
          if (rdy_rise) begin
            state     <= rq_idle;
            next_addr <= 1'b1;
          end
        end
        default: state <= rq_idle;
      endcase
    end
  end

  a_rq_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem_rrq && mem_wrq));

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_start || wr_start) |-> (state == rq_idle))
    else $error("memory start dropped, request still in flight");

endmodule

//--- logic/spi_byte_rx.sv
`timescale 1ns/1ns

module spi_byte_rx
  import spi_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  spi_sck,
  input  logic                  spi_ss_n,
  input  logic                  spi_mosi,
  input  logic [7:0]            tx_byte,
  output logic                  spi_miso,
  output logic                  cmd_strobe,
  output logic                  param_strobe,
  output logic [7:0]            rx_byte,
  output logic [7:0]            cmd_byte,
  output logic [byte_cnt_w-1:0] byte_cnt
);

  logic [2:0] sck_sync;
  logic [1:0] ss_sync;
  logic [1:0] mosi_sync;
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_idle;
  logic [2:0] bit_cnt;
  logic [6:0] rx_shift;
  logic [7:0] tx_shift;
  logic       tx_load;

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign ss_idle  = ss_sync[1];
  assign spi_miso = tx_shift[7];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sck_sync     <= '0;
      ss_sync      <= 2'b11;
      mosi_sync    <= '0;
      bit_cnt      <= '0;
      byte_cnt     <= '0;
      cmd_strobe   <= 1'b0;
      param_strobe <= 1'b0;
      tx_shift     <= '0;
      tx_load      <= 1'b0;
    end else begin
      sck_sync     <= {sck_sync[1:0], spi_sck};
      ss_sync      <= {ss_sync[0], spi_ss_n};
      mosi_sync    <= {mosi_sync[0], spi_mosi};
      cmd_strobe   <= 1'b0;
      param_strobe <= 1'b0;
      if (ss_idle) begin
        bit_cnt  <= '0;
        byte_cnt <= '0;
        tx_load  <= 1'b0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            // saturate so a long burst never looks like a new command
            if (byte_cnt != '1)
              byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == '0)
              cmd_strobe <= 1'b1;
            else
              param_strobe <= 1'b1;
          end
        end
        if (cmd_strobe || param_strobe)
          tx_load <= 1'b1;
        // mode 0: next bit goes out on the falling edge
        if (sck_fall) begin
          if (tx_load) begin
            tx_shift <= tx_byte;
            tx_load  <= 1'b0;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!ss_idle && sck_rise) begin
      rx_shift <= {rx_shift[5:0], mosi_sync[1]};
      if (bit_cnt == 3'd7) begin
        rx_byte <= {rx_shift, mosi_sync[1]};
        if (byte_cnt == '0)
          cmd_byte <= {rx_shift, mosi_sync[1]};
      end
    end
  end

  a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(cmd_strobe && param_strobe));

endmodule

//--- logic/spi_cmd_pkg.sv
package spi_cmd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // command opcodes
  ////////////////////////////////////////////////////////////////////////////

  // upper nibble of the command byte
  typedef enum logic [3:0] {
    op_set_addr   = 4'h0,
    op_rom_mask   = 4'h1,
    op_sram_mask  = 4'h2,
    op_set_mapper = 4'h3,
    op_mem_read   = 4'h8,
    op_mem_write  = 4'h9,
    op_misc       = 4'hE,
    op_info       = 4'hF
  } cmd_op_t;

  // full command codes
  localparam logic [7:0] info_signature_cmd = 8'hF0;
  localparam logic [7:0] info_freq_cmd      = 8'hFE;
  localparam logic [7:0] info_echo_cmd      = 8'hFF;
  localparam logic [7:0] misc_feature_cmd   = 8'hED;

  // returned by the signature command
  localparam logic [7:0] signature_byte = 8'hA5;

  ////////////////////////////////////////////////////////////////////////////
  // transfer framing
  ////////////////////////////////////////////////////////////////////////////

  // command byte is count 1, first parameter is count 2
  localparam int byte_cnt_w = 8;

  // address increment enable in read/write commands
  localparam int auto_inc_bit = 3;

endpackage

//--- logic/sysclk_meter.sv
`timescale 1ns/1ns

module sysclk_meter
  import mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ext_clk,
  output logic [freq_w-1:0] freq_count
);

  logic [2:0]                      ext_sync;
  logic                            ext_rise;
  logic                            win_end;
  logic [freq_w-1:0]               edge_cnt;
  logic [$clog2(meter_window)-1:0] win_cnt;

  assign ext_rise = ext_sync[1] & ~ext_sync[2];
  assign win_end  = (win_cnt == meter_window - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ext_sync   <= '0;
      edge_cnt   <= '0;
      win_cnt    <= '0;
      freq_count <= '0;
    end else begin
      ext_sync <= {ext_sync[1:0], ext_clk};
      if (win_end) begin
        // edge in the last cycle still belongs to this window
        freq_count <= edge_cnt + freq_w'(ext_rise);
        edge_cnt   <= '0;
        win_cnt    <= '0;
      end else begin
        edge_cnt <= edge_cnt + freq_w'(ext_rise);
        win_cnt  <= win_cnt + 1'b1;
      end
    end
  end

endmodule

//--- sources.f
logic/spi_cmd_pkg.sv
logic/mem_map_pkg.sv
logic/spi_byte_rx.sv
logic/mcu_cmd.sv
logic/mem_rq_fsm.sv
logic/sysclk_meter.sv
logic/cart_cmd_top.sv
testbench/cart_cmd_checker.sv
testbench/tb_cart_cmd.sv

//--- testbench/cart_cmd_checker.sv
`timescale 1ns/1ns

module cart_cmd_checker
  import spi_cmd_pkg::*;
  import mem_map_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              spi_sck,
  input  logic              spi_ss_n,
  input  logic              spi_mosi,
  input  logic              spi_miso,
  input  logic [addr_w-1:0] mem_addr,
  input  logic [7:0]        mem_data_out,
  input  logic              mem_rrq,
  input  logic              mem_wrq,
  input  mapper_t           mapper,
  input  logic [addr_w-1:0] rom_mask,
  input  logic [addr_w-1:0] sram_mask,
  input  logic [7:0]        feature_bits,
  output int                error_count,
  output int                check_count,
  output int                pending
);

  logic              sck_q;
  logic              ss_q;
  logic              reset_seen;
  int                bit_n;
  int                byte_n;
  logic [7:0]        mosi_sh;
  logic [7:0]        miso_sh;
  logic [7:0]        cmd;
  logic [7:0]        exp_reply [0:63];
  logic              exp_valid [0:63];
  logic [31:0]       freq_got;
  logic [addr_w-1:0] exp_addr;
  logic [addr_w-1:0] exp_rom;
  logic [addr_w-1:0] exp_sram;
  mapper_t           exp_mapper;
  logic [7:0]        exp_feature;
  logic [7:0]        exp_mem [logic [addr_w-1:0]];
  logic [addr_w-1:0] wr_addr_q [$];
  logic [7:0]        wr_data_q [$];
  logic [addr_w-1:0] rd_addr_q [$];

  function automatic logic [7:0] mem_value(input logic [addr_w-1:0] a);
    if (exp_mem.exists(a))
      return exp_mem[a];
    return a[23:16] ^ a[15:8] ^ a[7:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic clear_model();
    exp_mapper  = map_hi;
    exp_rom     = '0;
    exp_sram    = '0;
    exp_feature = '0;
    exp_addr    = '0;
    bit_n       = 0;
    byte_n      = 0;
    cmd         = '0;
    reset_seen  = 1'b0;
    error_count = 0;
    check_count = 0;
    pending     = 0;
    exp_mem.delete();
    wr_addr_q.delete();
    wr_data_q.delete();
    rd_addr_q.delete();
  endtask

  task automatic check_registers();
    check_value("mapper", exp_mapper, mapper);
    check_value("rom_mask", exp_rom, rom_mask);
    check_value("sram_mask", exp_sram, sram_mask);
    check_value("feature_bits", exp_feature, feature_bits);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model, one decoded SPI byte at a time
  ////////////////////////////////////////////////////////////////////////////

  task automatic take_byte(input logic [7:0] b, input logic [7:0] reply);
    int k;
    k = byte_n;
    if (k == 1)
      cmd = b;
    if (exp_valid[k])
      check_value("spi_miso", exp_reply[k], reply);
    if (cmd == info_freq_cmd && k >= 3 && k <= 6)
      freq_got = {freq_got[23:0], reply};
    case (cmd_op_t'(cmd[7:4]))
      op_set_addr: begin
        if (k == 2)
          exp_addr = '0;
        if (k >= 2 && k <= 4)
          exp_addr[8*(4-k) +: 8] = b;
      end
      op_rom_mask:
        if (k >= 2 && k <= 4)
          exp_rom[8*(4-k) +: 8] = b;
      op_sram_mask:
        if (k >= 2 && k <= 4)
          exp_sram[8*(4-k) +: 8] = b;
      op_set_mapper:
        if (k == 1)
          exp_mapper = mapper_t'(b[2:0]);
      op_misc:
        if (cmd == misc_feature_cmd && k >= 2)
          exp_feature = b;
      op_mem_write: begin
        if (k >= 2) begin
          wr_addr_q.push_back(exp_addr);
          wr_data_q.push_back(b);
          exp_mem[exp_addr] = b;
          if (cmd[auto_inc_bit])
            exp_addr++;
        end
      end
      op_mem_read: begin
        // every read byte fetches, the address moves from byte 2 on
        rd_addr_q.push_back(exp_addr);
        exp_reply[k+1] = mem_value(exp_addr);
        exp_valid[k+1] = 1'b1;
        if (k >= 2 && cmd[auto_inc_bit])
          exp_addr++;
      end
      op_info: begin
        if (cmd == info_signature_cmd || cmd == info_echo_cmd) begin
          exp_reply[k+1] = (cmd == info_signature_cmd) ? signature_byte : b;
          exp_valid[k+1] = 1'b1;
        end
      end
      default: ;
    endcase
  endtask

  task automatic sample_bit();
    mosi_sh = {mosi_sh[6:0], spi_mosi};
    miso_sh = {miso_sh[6:0], spi_miso};
    bit_n++;
    if (bit_n == 8) begin
      bit_n = 0;
      byte_n++;
      if (byte_n < 63)
        take_byte(mosi_sh, miso_sh);
    end
  endtask

  task automatic end_transfer();
    check_registers();
    if (cmd == info_freq_cmd && byte_n >= 6) begin
      check_count++;
      if (freq_got < meter_window / 8 - 1 || freq_got > meter_window / 8 + 1) begin
        error_count++;
        $display("[FAIL] %0t freq_count expected %0d+/-1 actual %0d",
                 $time, meter_window / 8, freq_got);
      end
    end
  endtask

  task automatic check_write();
    if (wr_addr_q.size() == 0) begin
      error_count++;
      $display("%0t unexpected memory write request at address %h", $time, mem_addr);
    end else begin
      check_value("mem_addr", wr_addr_q.pop_front(), mem_addr);
      check_value("mem_data_out", wr_data_q.pop_front(), mem_data_out);
    end
  endtask

  task automatic check_read();
    if (rd_addr_q.size() == 0) begin
      error_count++;
      $display("%0t unexpected memory read request at address %h", $time, mem_addr);
    end else begin
      check_value("mem_addr", rd_addr_q.pop_front(), mem_addr);
    end
  endtask

  always @(posedge clk) begin
    sck_q <= spi_sck;
    ss_q  <= spi_ss_n;
    if (!rst_n) begin
      clear_model();
    end else begin
      if (!reset_seen) begin
        check_registers();
        check_value("mem_rrq", 1'b0, mem_rrq);
        check_value("mem_wrq", 1'b0, mem_wrq);
        check_value("spi_miso", 1'b0, spi_miso);
        reset_seen = 1'b1;
      end
      if (!spi_ss_n && ss_q) begin
        bit_n    = 0;
        byte_n   = 0;
        freq_got = '0;
        foreach (exp_valid[i])
          exp_valid[i] = 1'b0;
      end
      if (!spi_ss_n && spi_sck && !sck_q)
        sample_bit();
      if (spi_ss_n && !ss_q)
        end_transfer();
      if (mem_wrq)
        check_write();
      if (mem_rrq)
        check_read();
      pending <= wr_addr_q.size() + rd_addr_q.size();
    end
  end

endmodule

//--- testbench/tb_cart_cmd.sv
`timescale 1ns/1ns

module tb_cart_cmd
  import spi_cmd_pkg::*;
  import mem_map_pkg::*;
();

  logic              clk;
  logic              rst_n;
  logic              spi_sck;
  logic              spi_ss_n;
  logic              spi_mosi;
  logic              ext_clk;
  logic [7:0]        mem_data_in;
  logic              mem_rq_rdy;
  logic              spi_miso;
  logic [addr_w-1:0] mem_addr;
  logic [7:0]        mem_data_out;
  logic              mem_rrq;
  logic              mem_wrq;
  mapper_t           mapper;
  logic [addr_w-1:0] rom_mask;
  logic [addr_w-1:0] sram_mask;
  logic [7:0]        feature_bits;
  int                error_count;
  int                check_count;
  int                pending;
  int                cycle = 0;
  int                lat_table [0:255];
  logic [7:0]        xfer_q [$];
  logic [7:0]        mem_store [logic [addr_w-1:0]];

  cart_cmd_top i_cart_cmd_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_sck      (spi_sck),
    .spi_ss_n     (spi_ss_n),
    .spi_mosi     (spi_mosi),
    .ext_clk      (ext_clk),
    .mem_data_in  (mem_data_in),
    .mem_rq_rdy   (mem_rq_rdy),
    .spi_miso     (spi_miso),
    .mem_addr     (mem_addr),
    .mem_data_out (mem_data_out),
    .mem_rrq      (mem_rrq),
    .mem_wrq      (mem_wrq),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .sram_mask    (sram_mask),
    .feature_bits (feature_bits)
  );

  cart_cmd_checker i_cart_cmd_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi_sck      (spi_sck),
    .spi_ss_n     (spi_ss_n),
    .spi_mosi     (spi_mosi),
    .spi_miso     (spi_miso),
    .mem_addr     (mem_addr),
    .mem_data_out (mem_data_out),
    .mem_rrq      (mem_rrq),
    .mem_wrq      (mem_wrq),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .sram_mask    (sram_mask),
    .feature_bits (feature_bits),
    .error_count  (error_count),
    .check_count  (check_count),
    .pending      (pending)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
    cycle <= cycle + 1;

  // console clock, period of 8 clk cycles
  initial begin
    ext_clk <= 1'b0;
    forever begin
      repeat (4) @(posedge clk);
      ext_clk <= ~ext_clk;
    end
  end

  function automatic logic [7:0] stored_byte(input logic [addr_w-1:0] a);
    if (mem_store.exists(a))
      return mem_store[a];
    return a[23:16] ^ a[15:8] ^ a[7:0];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    int                rq_n;
    logic [addr_w-1:0] a;
    logic [7:0]        d;
    logic              wr;
    rq_n = 0;
    mem_rq_rdy  <= 1'b0;
    mem_data_in <= 8'h00;
    forever begin
      @(posedge clk);
      if (rst_n && (mem_rrq || mem_wrq)) begin
        a  = mem_addr;
        d  = mem_data_out;
        wr = mem_wrq;
        repeat (lat_table[rq_n % 256]) @(posedge clk);
        rq_n++;
        if (wr)
          mem_store[a] = d;
        else
          mem_data_in <= stored_byte(a);
        mem_rq_rdy <= 1'b1;
        @(posedge clk);
        mem_rq_rdy <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // SPI master, mode 0, sck at clk/20
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi <= b[i];
      repeat (10) @(posedge clk);
      spi_sck <= 1'b1;
      // long last high phase gives the readback byte time before the load
      repeat ((i == 0) ? 30 : 10) @(posedge clk);
      spi_sck <= 1'b0;
    end
  endtask

  task automatic send_transfer();
    spi_ss_n <= 1'b0;
    repeat (10) @(posedge clk);
    while (xfer_q.size() > 0)
      send_byte(xfer_q.pop_front());
    repeat (10) @(posedge clk);
    spi_ss_n <= 1'b1;
    repeat (20) @(posedge clk);
  endtask

  task automatic set_address(input logic [addr_w-1:0] a);
    xfer_q.push_back({op_set_addr, 4'h0});
    xfer_q.push_back(a[23:16]);
    xfer_q.push_back(a[15:8]);
    xfer_q.push_back(a[7:0]);
    send_transfer();
  endtask

  initial begin : stimulus
    logic [31:0]       r;
    logic [addr_w-1:0] start;
    int                len;
    int                timeout;
    void'($urandom(51));
    rst_n    <= 1'b0;
    spi_sck  <= 1'b0;
    spi_ss_n <= 1'b1;
    spi_mosi <= 1'b0;
    foreach (lat_table[i])
      lat_table[i] = $urandom_range(10, 1);
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (5) @(posedge clk);

    // random configuration commands
    for (int t = 0; t < 10; t++) begin
      r = $urandom;
      case ($urandom_range(3, 0))
        0: xfer_q.push_back({op_set_mapper, 4'($urandom_range(5, 0))});
        1: xfer_q.push_back({op_rom_mask, 4'h0});
        2: xfer_q.push_back({op_sram_mask, 4'h0});
        default: xfer_q.push_back(misc_feature_cmd);
      endcase
      if (xfer_q[0][7:4] == op_rom_mask || xfer_q[0][7:4] == op_sram_mask) begin
        xfer_q.push_back(r[23:16]);
        xfer_q.push_back(r[15:8]);
        xfer_q.push_back(r[7:0]);
      end else if (xfer_q[0] == misc_feature_cmd) begin
        xfer_q.push_back(r[7:0]);
      end
      send_transfer();
    end

    // write burst, then read it back with one extra address
    start = addr_w'($urandom);
    len   = $urandom_range(8, 1);
    set_address(start);
    xfer_q.push_back({op_mem_write, 4'b1000});
    for (int i = 0; i < len; i++)
      xfer_q.push_back(8'($urandom));
    send_transfer();
    set_address(start);
    xfer_q.push_back({op_mem_read, 4'b1000});
    for (int i = 0; i < len + 2; i++)
      xfer_q.push_back(8'h00);
    send_transfer();

    xfer_q.push_back(info_signature_cmd);
    for (int i = 0; i < 3; i++)
      xfer_q.push_back(8'($urandom));
    send_transfer();
    xfer_q.push_back(info_echo_cmd);
    for (int i = 0; i < 4; i++)
      xfer_q.push_back(8'($urandom));
    send_transfer();

    // needs at least one finished meter window
    while (cycle < 2 * meter_window)
      @(posedge clk);
    xfer_q.push_back(info_freq_cmd);
    for (int i = 0; i < 5; i++)
      xfer_q.push_back(8'h00);
    send_transfer();

    timeout = 0;
    while (pending != 0 && timeout < 200) begin
      @(posedge clk);
      timeout++;
    end
    if (pending != 0) begin
      $display("memory requests still outstanding after %0d cycles", timeout);
      $display("** FAIL **");
    end else begin
      $display("checks %0d errors %0d", check_count, error_count);
      if (error_count == 0)
        $display("** PASS **");
      else
        $display("** FAIL **");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (100000) @(posedge clk);
    $display("simulation did not finish within its cycle limit");
    $display("** FAIL **");
    $finish;
  end

endmodule
